/* hw/panel_consts.svh */
`ifndef PANEL_CONSTS_SVH
`define PANEL_CONSTS_SVH

// hold time is 2**DEBOUNCE_BITS cycles of a steady button.
`define DEBOUNCE_BITS 21

// cycles each digit stays lit.
`define SCAN_TICKS 25000

// active low, so all ones is dark.
`define SEG_BLANK 7'b111_1111

`endif

/* hw/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    // the value kept by the panel, mirrored on the leds.
    typedef logic [15:0] panel_value_t;

    // debouncer states.
    typedef enum logic [1:0] {
        deb_idle,
        deb_counting,
        deb_fire,
        deb_wait_release
    } deb_state_t;

endpackage

`default_nettype wire

/* hw/disp_pkg.sv */
`default_nettype none

package disp_pkg;

    // one hex digit.
    typedef logic [3:0] nibble_t;

    // active-low segments, bit 0 is a and bit 6 is g.
    typedef logic [6:0] seg_t;

    // active-low digit enable, bit 0 is the rightmost digit.
    typedef logic [3:0] anode_t;

    // which of the four digits is lit.
    typedef logic [1:0] digit_sel_t;

endpackage

`default_nettype wire

/* hw/value_bus_if.sv */
`default_nettype none
`timescale 1ns/100ps

// one writer's path into the shared value register.
interface value_bus_if;
    import ctrl_pkg::*;

    logic         req;    // held while a write is pending.
    panel_value_t wdata;
    logic         grant;  // combinational, same cycle as req.
    panel_value_t value;  // current register contents.

    modport writer (
        output req,
        output wdata,
        input  grant,
        input  value
    );

    modport arbiter (
        input  req,
        input  wdata,
        output grant,
        output value
    );

endinterface

`default_nettype wire

/* hw/button_debounce.sv */
`default_nettype none
`timescale 1ns/100ps

`include "panel_consts.svh"

module button_debounce #(
    parameter int hold_bits = `DEBOUNCE_BITS
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  button,
    output logic press
);
    import ctrl_pkg::*;

    deb_state_t       state;
    deb_state_t       state_next;
    logic [hold_bits:0] hold_cnt;
    logic [hold_bits:0] hold_cnt_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= deb_idle;
            hold_cnt <= '0;
        end else begin
            state    <= state_next;
            hold_cnt <= hold_cnt_next;
        end
    end

    always_comb begin
        state_next    = state;
        hold_cnt_next = '0;
        case (state)
            deb_idle: begin
                if (button) state_next = deb_counting;
            end
            deb_counting: begin
                if (!button) begin
                    state_next = deb_idle;          // bounce, start over.
                end else if (hold_cnt[hold_bits]) begin
                    state_next = deb_fire;
                end else begin
                    hold_cnt_next = hold_cnt + 1'b1;
                end
            end
            deb_fire: begin
                state_next = deb_wait_release;
            end
            deb_wait_release: begin
                if (!button) state_next = deb_idle; // one pulse per press.
            end
            default: state_next = deb_idle;
        endcase
    end

    assign press = (state == deb_fire);

endmodule

`default_nettype wire

/* hw/tally_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module tally_unit (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         up,
    input  wire         down,
    value_bus_if.writer bus
);
    import ctrl_pkg::*;

    logic pend_valid;
    logic pend_up;    // direction of the pending step.
    logic step;

    // both pulses together cancel out.
    assign step = up ^ down;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
        end else if (step) begin
            pend_valid <= 1'b1;
        end else if (bus.grant) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            pend_up <= up;
        end
    end

    assign bus.req = pend_valid;

    // built from the live value, so a delayed step still lands right.
    always_comb begin
        if (pend_up) begin
            bus.wdata = bus.value + panel_value_t'(1);
        end else begin
            bus.wdata = bus.value - panel_value_t'(1);
        end
    end

endmodule

`default_nettype wire

/* hw/switch_loader.sv */
`default_nettype none
`timescale 1ns/100ps

module switch_loader (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    load,
    input  wire ctrl_pkg::panel_value_t switches,
    value_bus_if.writer            bus
);
    import ctrl_pkg::*;

    logic         pend_valid;
    panel_value_t load_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
        end else if (load) begin
            pend_valid <= 1'b1;
        end else if (bus.grant) begin
            pend_valid <= 1'b0;
        end
    end

    // a later load simply recaptures.
    always_ff @(posedge clk) begin
        if (load) begin
            load_data <= switches;
        end
    end

    assign bus.req   = pend_valid;
    assign bus.wdata = load_data;

endmodule

`default_nettype wire

/* hw/value_arbiter.sv */
`default_nettype none
`timescale 1ns/100ps

module value_arbiter (
    input  wire                     clk,
    input  wire                     rst_n,
    value_bus_if.arbiter            load_bus,
    value_bus_if.arbiter            tally_bus,
    output ctrl_pkg::panel_value_t  value
);
    import ctrl_pkg::*;

    panel_value_t value_q;
    logic         load_win;
    logic         tally_win;

    // loader first, tally only when the loader is quiet.
    assign load_win  = load_bus.req;
    assign tally_win = tally_bus.req & ~load_bus.req;

    assign load_bus.grant  = load_win;
    assign tally_bus.grant = tally_win;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value_q <= '0;
        end else if (load_win) begin
            value_q <= load_bus.wdata;
        end else if (tally_win) begin
            value_q <= tally_bus.wdata;
        end
    end

    assign load_bus.value  = value_q;
    assign tally_bus.value = value_q;
    assign value           = value_q;

endmodule

`default_nettype wire

/* hw/seg_scan.sv */
`default_nettype none
`timescale 1ns/100ps

`include "panel_consts.svh"

module seg_scan #(
    parameter int scan_ticks = `SCAN_TICKS
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire ctrl_pkg::panel_value_t value,
    output disp_pkg::seg_t          segments,
    output disp_pkg::anode_t        anode
);
    import disp_pkg::*;

    localparam int timer_w = $clog2(scan_ticks + 1);

    logic [timer_w-1:0] digit_timer;
    digit_sel_t         digit_sel;
    nibble_t            digit;
    logic               blank;

    function automatic seg_t hex_to_seg(input nibble_t hex);
        case (hex)
            4'h0: return 7'b100_0000;
            4'h1: return 7'b111_1001;
            4'h2: return 7'b010_0100;
            4'h3: return 7'b011_0000;
            4'h4: return 7'b001_1001;
            4'h5: return 7'b001_0010;
            4'h6: return 7'b000_0010;
            4'h7: return 7'b111_1000;
            4'h8: return 7'b000_0000;
            4'h9: return 7'b001_0000;
            4'ha: return 7'b000_1000;
            4'hb: return 7'b000_0011;
            4'hc: return 7'b100_0110;
            4'hd: return 7'b010_0001;
            4'he: return 7'b000_0110;
            default: return 7'b000_1110;    // f.
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digit_timer <= '0;
            digit_sel   <= '0;
        end else if (digit_timer == timer_w'(scan_ticks - 1)) begin
            digit_timer <= '0;
            digit_sel   <= digit_sel + digit_sel_t'(1);  // wraps 3 to 0.
        end else begin
            digit_timer <= digit_timer + 1'b1;
        end
    end

    always_comb begin
        blank = 1'b0;
        digit = value[3:0];
        case (digit_sel)
            2'd0: begin anode = 4'b1110; digit = value[3:0];   end
            2'd1: begin anode = 4'b1101; digit = value[7:4];   end
            2'd2: begin anode = 4'b1011; digit = value[11:8];  end
            2'd3: begin anode = 4'b0111; digit = value[15:12]; end
            default: begin
                anode = 4'b1111;
                blank = 1'b1;
            end
        endcase
    end

    assign segments = blank ? `SEG_BLANK : hex_to_seg(digit);

endmodule

`default_nettype wire

/* hw/panel_top.sv */
`default_nettype none
`timescale 1ns/100ps

`include "panel_consts.svh"

module panel_top #(
    parameter int debounce_bits = `DEBOUNCE_BITS,
    parameter int scan_ticks    = `SCAN_TICKS
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     btn_up,
    input  wire                     btn_down,
    input  wire                     btn_load,
    input  wire ctrl_pkg::panel_value_t switches,
    output disp_pkg::seg_t          segments,
    output disp_pkg::anode_t        anode,
    output ctrl_pkg::panel_value_t  led
);
    import ctrl_pkg::*;

    logic         up_press;
    logic         down_press;
    logic         load_press;
    panel_value_t value;

    value_bus_if load_bus ();
    value_bus_if tally_bus ();

    button_debounce #(.hold_bits(debounce_bits)) u_deb_up (
        .clk    (clk),
        .rst_n  (rst_n),
        .button (btn_up),
        .press  (up_press)
    );

    button_debounce #(.hold_bits(debounce_bits)) u_deb_down (
        .clk    (clk),
        .rst_n  (rst_n),
        .button (btn_down),
        .press  (down_press)
    );

    button_debounce #(.hold_bits(debounce_bits)) u_deb_load (
        .clk    (clk),
        .rst_n  (rst_n),
        .button (btn_load),
        .press  (load_press)
    );

    tally_unit u_tally (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (up_press),
        .down  (down_press),
        .bus   (tally_bus.writer)
    );

    switch_loader u_loader (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load_press),
        .switches (switches),
        .bus      (load_bus.writer)
    );

    value_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_bus  (load_bus.arbiter),
        .tally_bus (tally_bus.arbiter),
        .value     (value)
    );

    seg_scan #(.scan_ticks(scan_ticks)) u_scan (
        .clk      (clk),
        .rst_n    (rst_n),
        .value    (value),
        .segments (segments),
        .anode    (anode)
    );

    assign led = value;    // leds mirror the register.

endmodule

`default_nettype wire

/* dv/panel_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module panel_tb;
    import ctrl_pkg::*;
    import disp_pkg::*;

    localparam int debounce_bits = 3;
    localparam int scan_ticks    = 4;
    localparam int hold_cycles   = 2 ** debounce_bits;
    localparam int led_timeout   = hold_cycles + 8;  // pulse, request and write on top of the hold.
    localparam int press_budget  = led_timeout + 4;
    localparam int num_presses   = 32;
    localparam int watchdog_cycles = 2 + num_presses * press_budget + 6 * hold_cycles
                                     + 16 * scan_ticks + 200;

    logic         clk;
    logic         rst_n;
    logic         btn_up;
    logic         btn_down;
    logic         btn_load;
    panel_value_t switches;
    seg_t         segments;
    anode_t       anode;
    panel_value_t led;

    int           check_count;
    int           fail_count;
    int           test_count;
    panel_value_t model_value;
    logic [31:0]  rng;

    panel_top #(
        .debounce_bits (debounce_bits),
        .scan_ticks    (scan_ticks)
    ) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .btn_up   (btn_up),
        .btn_down (btn_down),
        .btn_load (btn_load),
        .switches (switches),
        .segments (segments),
        .anode    (anode),
        .led      (led)
    );

    always #5 clk = ~clk;

    // exactly one digit enabled at any time.
    assert property (@(posedge clk) disable iff (!rst_n) $onehot(~anode))
    else begin
        $display("CHECK FAILED anode: %h is not one-hot low", anode);
        fail_count++;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic expect_equal(input string name, input panel_value_t got,
                                input panel_value_t exp);
        check_count++;
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            fail_count++;
        end
    endtask

    task automatic wait_for_led(input panel_value_t exp, input string what);
        int n;
        n = 0;
        while (led !== exp && n < led_timeout) begin
            @(negedge clk);
            n++;
        end
        check_count++;
        assert (led === exp) else begin
            $display("led did not reach %h within %0d cycles after the %s press, it shows %h",
                     exp, led_timeout, what, led);
            fail_count++;
        end
    endtask

    // lit segments are written gfedcba, active high.
    task automatic decode_display(output int idx, output nibble_t nib, output bit valid);
        valid = 1'b1;
        case (anode)
            4'b1110: idx = 0;
            4'b1101: idx = 1;
            4'b1011: idx = 2;
            4'b0111: idx = 3;
            default: idx = -1;
        endcase
        nib = 4'h0;
        case (~segments)
            7'b011_1111: nib = 4'h0;
            7'b000_0110: nib = 4'h1;
            7'b101_1011: nib = 4'h2;
            7'b100_1111: nib = 4'h3;
            7'b110_0110: nib = 4'h4;
            7'b110_1101: nib = 4'h5;
            7'b111_1101: nib = 4'h6;
            7'b000_0111: nib = 4'h7;
            7'b111_1111: nib = 4'h8;
            7'b110_1111: nib = 4'h9;
            7'b111_0111: nib = 4'ha;
            7'b111_1100: nib = 4'hb;
            7'b011_1001: nib = 4'hc;
            7'b101_1110: nib = 4'hd;
            7'b111_1001: nib = 4'he;
            7'b111_0001: nib = 4'hf;
            default:     valid = 1'b0;
        endcase
        if (idx < 0) valid = 1'b0;
    endtask

    // which is 0 for up, 1 for down, 2 for load.
    task automatic press_and_wait(input int which, input panel_value_t exp, input string what);
        @(negedge clk);
        case (which)
            0: btn_up = 1'b1;
            1: btn_down = 1'b1;
            default: btn_load = 1'b1;
        endcase
        wait_for_led(exp, what);
        @(negedge clk);
        btn_up   = 1'b0;
        btn_down = 1'b0;
        btn_load = 1'b0;
        repeat (2) @(negedge clk);  // debouncer back to idle.
    endtask

    task automatic finish_test(input string name, input int fails_before);
        test_count++;
        if (fail_count == fails_before)
            $display("test %s: pass", name);
        else
            $display("test %s: %0d failed checks", name, fail_count - fails_before);
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("tests failed");
        $finish;
    end

    initial begin
        int           start_fails;
        int           idx;
        int           prev_idx;
        int           steps;
        nibble_t      nib;
        bit           valid;
        bit           changed;
        panel_value_t sw;

        clk         = 1'b0;
        rst_n       = 1'b0;
        btn_up      = 1'b0;
        btn_down    = 1'b0;
        btn_load    = 1'b0;
        switches    = '0;
        check_count = 0;
        fail_count  = 0;
        test_count  = 0;
        model_value = '0;
        rng         = 32'd54;

        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        start_fails = fail_count;
        expect_equal("led", led, model_value);
        expect_equal("anode", panel_value_t'(anode), panel_value_t'(4'b1110));
        // zero lights every segment but g.
        expect_equal("segments", panel_value_t'(segments), panel_value_t'(7'b100_0000));
        finish_test("reset", start_fails);

        start_fails = fail_count;
        @(negedge clk);
        btn_up = 1'b1;
        repeat (hold_cycles - 3) @(negedge clk);  // too short to count.
        btn_up = 1'b0;
        repeat (hold_cycles + 4) @(negedge clk);
        expect_equal("led", led, model_value);
        btn_up = 1'b1;
        model_value = model_value + 16'd1;
        wait_for_led(model_value, "long up");
        repeat (2 * hold_cycles) @(negedge clk);  // still held.
        expect_equal("led", led, model_value);
        btn_up = 1'b0;
        repeat (2) @(negedge clk);
        for (int i = 0; i < 10; i++) begin
            model_value = model_value + 16'd1;
            press_and_wait(0, model_value, "up");
        end
        expect_equal("led", led, 16'd11);
        for (int i = 0; i < 12; i++) begin
            model_value = model_value - 16'd1;
            press_and_wait(1, model_value, "down");
        end
        expect_equal("led", led, 16'hffff);
        finish_test("buttons", start_fails);

        start_fails = fail_count;
        rng = xorshift32(rng);
        sw  = rng[15:0];
        if (sw == model_value) sw = sw ^ 16'h0001;
        switches    = sw;
        model_value = sw;
        press_and_wait(2, model_value, "load");
        expect_equal("led", led, switches);
        finish_test("switch load", start_fails);

        start_fails = fail_count;
        rng = xorshift32(rng);
        sw  = rng[15:0];
        if (sw == model_value || sw + 16'd1 == model_value) sw = model_value + 16'h1234;
        @(negedge clk);
        switches = sw;
        btn_load = 1'b1;
        btn_up   = 1'b1;
        model_value = sw;
        wait_for_led(model_value, "load and up");
        @(negedge clk);
        model_value = model_value + 16'd1;  // the increment lands one cycle later.
        expect_equal("led", led, model_value);
        btn_load = 1'b0;
        btn_up   = 1'b0;
        repeat (4) @(negedge clk);
        expect_equal("led", led, model_value);
        finish_test("contention", start_fails);

        start_fails = fail_count;
        changed = 1'b0;
        @(negedge clk);
        btn_up   = 1'b1;
        btn_down = 1'b1;
        repeat (hold_cycles + 8) begin
            @(negedge clk);
            if (led !== model_value) changed = 1'b1;
        end
        btn_up   = 1'b0;
        btn_down = 1'b0;
        repeat (4) @(negedge clk);
        check_count++;
        assert (!changed) else begin
            $display("led moved while up and down were pressed together");
            fail_count++;
        end
        expect_equal("led", led, model_value);
        finish_test("up and down", start_fails);

        start_fails = fail_count;
        switches    = 16'h7e31;  // four different digits.
        model_value = 16'h7e31;
        press_and_wait(2, model_value, "load");
        prev_idx = -1;
        steps    = 0;
        repeat (16 * scan_ticks) begin
            @(negedge clk);
            decode_display(idx, nib, valid);
            check_count++;
            assert (valid) else begin
                $display("display shows no readable digit, anode %h segments %h",
                         anode, segments);
                fail_count++;
            end
            if (valid) begin
                expect_equal("digit", panel_value_t'(nib),
                             panel_value_t'(model_value[idx*4 +: 4]));
                if (prev_idx >= 0 && idx != prev_idx) begin
                    expect_equal("digit index", panel_value_t'(idx),
                                 panel_value_t'((prev_idx + 1) % 4));
                    steps++;
                end
                prev_idx = idx;
            end
        end
        check_count++;
        assert (steps >= 15) else begin
            $display("scan advanced only %0d times in 16 periods", steps);
            fail_count++;
        end
        finish_test("display scan", start_fails);

        $display("summary: %0d tests, %0d checks, %0d failures",
                 test_count, check_count, fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hw
hw/ctrl_pkg.sv
hw/disp_pkg.sv
hw/value_bus_if.sv
hw/button_debounce.sv
hw/tally_unit.sv
hw/switch_loader.sv
hw/value_arbiter.sv
hw/seg_scan.sv
hw/panel_top.sv
dv/panel_tb.sv

/* run.sh */
#!/bin/sh
# builds the panel testbench with Verilator and runs it.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f filelist.f --top-module panel_tb -o panel_sim \
    && ./obj_dir/panel_sim | tee /dev/stderr | grep -q "all tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
